// ==== verif/pulse_golden.txt ====
# kind cmd data echo pre post p1 p2 pulses gap  (R reset check, F frame, U random frames)
# cmd data echo pre post in hex, the rest decimal; for U, data is the number of frames
R 00 00000000 00 00 7f 40 40 2 150
F 06 12e5c3a1 5b 21 43 40 40 2 150
F 01 000003e8 eb 21 43 40 40 2 150
F 02 00000019 19 21 43 25 40 2 150
F 03 abcd0030 a8 21 43 25 48 2 150
F 05 00000003 03 21 43 25 48 4 150
F 00 00000064 64 21 43 25 48 4 100
U 04 00000006 00 21 43 25 48 4 100
F 06 00007f00 7f 00 7f 25 48 4 100
F 05 00000000 00 00 7f 25 48 1 100
F 02 ffff0040 3e 00 7f 64 48 1 100
F 07 12345678 14 00 7f 64 48 1 100
F 05 00000002 02 00 7f 64 48 3 100
U 7f 00000004 00 00 7f 64 48 3 100
F 06 00001a6c 86 6c 1a 64 48 3 100
F 01 00000bb8 c3 6c 1a 64 48 3 100
F 03 0000000a 0a 6c 1a 64 10 3 100
F 00 000000c8 c8 6c 1a 64 10 3 200

// ==== pulse_top.f ====
common/pulse_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
logic/pulse_control.sv
logic/pulse_sequencer.sv
logic/pulse_top.sv
verif/pulse_top_tb.sv

// ==== Makefile ====
# Verilator build and run of the pulse programmer testbench

VERILATOR ?= verilator
TOP       ?= pulse_top_tb
FILELIST  ?= pulse_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) | tee $(LOG)
	@grep -q "^test passed$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/pulse_top_tb.sv ====
`timescale 1ns/1ps

module pulse_top_tb;

   localparam int BIT_CLKS = 8;                    // Short bit time for simulation

   typedef struct packed {
      pulse_pkg::byte_t kind;                      // R reset, F frame, U random frames
      pulse_pkg::byte_t cmd;
      logic [31:0]      data;                      // Payload, or frame count for U
      logic [31:0]      echo;
      logic [31:0]      pre;
      logic [31:0]      post;
      logic [31:0]      p1;
      logic [31:0]      p2;
      logic [31:0]      pulses;                    // Pulses per period
      logic [31:0]      gap;                       // Low time between pulses
   } golden_t;

   logic            clk;
   logic            rst_n;
   logic            rx;
   logic            tx;
   logic            pulse;
   pulse_pkg::att_t pre_att;
   pulse_pkg::att_t post_att;
   golden_t         rows[$];
   logic [31:0]     lfsr_state;
   int              wd_cycles;

   pulse_top #(
      .CLKS_PER_BIT(BIT_CLKS)
   ) dut_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .rx      (rx),
      .tx      (tx),
      .pulse   (pulse),
      .pre_att (pre_att),
      .post_att(post_att)
   );

   always #20 clk = ~clk;                          // 40 ns period

   task automatic fail_run(input string reason);
      $display("%s", reason);
      $display("test failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         fail_run($sformatf("ERROR at %0t ns: %s expected 0x%0h, got 0x%0h",
                            $time, name, expected, actual));
      end
   endtask

   // Galois form, polynomial x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic next_random_word(output pulse_pkg::word_t w);
      for (int i = 0; i < 32; i++) begin
         w[i]       = lfsr_state[0];               // One step per bit
         lfsr_state = lfsr_step(lfsr_state);
      end
   endtask

   function automatic pulse_pkg::byte_t checksum_of(input pulse_pkg::word_t w);
      return w[7:0] + w[15:8] + w[23:16] + w[31:24];   // Wraps at 8 bits
   endfunction

   task automatic load_golden();
      int          fd;
      int          n;
      string       line;
      golden_t     row;
      logic [31:0] f_cmd;
      fd = $fopen("verif/pulse_golden.txt", "r");
      if (fd == 0) fail_run("Cannot open the golden file verif/pulse_golden.txt");
      while (!$feof(fd)) begin
         line = "";
         n    = $fgets(line, fd);
         if (line.len() > 1 && line.getc(0) != "#") begin
            n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %d %d %d %d",
                        f_cmd, row.data, row.echo, row.pre, row.post,
                        row.p1, row.p2, row.pulses, row.gap);
            if (n != 9) fail_run($sformatf("Golden file line is malformed: %s", line));
            row.kind = line.getc(0);
            row.cmd  = f_cmd[7:0];
            rows.push_back(row);
         end
      end
      $fclose(fd);
      if (rows.size() == 0) fail_run("The golden file holds no test rows");
   endtask

   // Frames with echo plus five of the longest periods per row
   task automatic set_watchdog();
      int frames;
      int longest;
      frames  = 0;
      longest = int'(pulse_pkg::RST_PERIOD);
      foreach (rows[i]) begin
         if (rows[i].kind == "F") frames += 1;
         if (rows[i].kind == "U") frames += int'(rows[i].data);
         if (rows[i].kind == "F" && rows[i].cmd == pulse_pkg::CMD_SET_PERIOD &&
             int'(rows[i].data) > longest) longest = int'(rows[i].data);
      end
      wd_cycles = frames * 60 * BIT_CLKS + rows.size() * 5 * longest + 64;
   endtask

   task automatic send_bit(input logic value);
      rx <= value;
      repeat (BIT_CLKS) @(posedge clk);
   endtask

   task automatic send_byte(input pulse_pkg::byte_t value);
      send_bit(1'b0);                              // Start bit
      for (int i = 0; i < 8; i++) send_bit(value[i]);   // LSB first
      send_bit(1'b1);
   endtask

   task automatic send_frame(input pulse_pkg::byte_t cmd, input pulse_pkg::word_t data);
      @(posedge clk);
      for (int i = 0; i < 4; i++) send_byte(data[8*i +: 8]);   // Little-endian payload
      send_byte(cmd);
   endtask

   // Sampled on the falling edge, away from tx updates
   task automatic receive_byte(output pulse_pkg::byte_t data);
      @(negedge clk);
      while (tx) @(negedge clk);
      repeat (BIT_CLKS / 2) @(negedge clk);       // Middle of the start bit
      if (tx) fail_run("Start bit on tx went high before mid-bit");
      for (int i = 0; i < 8; i++) begin
         repeat (BIT_CLKS) @(negedge clk);
         data[i] = tx;
      end
      repeat (BIT_CLKS) @(negedge clk);
      if (!tx) fail_run("Stop bit of the echo on tx was low");
   endtask

   task automatic exchange_frame(input pulse_pkg::byte_t cmd, input pulse_pkg::word_t data,
                                 input logic [31:0] expected);
      pulse_pkg::byte_t echo;
      fork
         send_frame(cmd, data);
         receive_byte(echo);                       // Echo may start inside the last stop bit
      join
      check_value("echo on tx", expected, 32'(echo));
   endtask

   // High runs and gaps of one pulse train, from its first rise
   task automatic measure_period(input int gap_limit, output int p1_len, output int p2_min,
                                 output int p2_max, output int gap_min, output int gap_max,
                                 output int n_pulses);
      int   low_run;
      int   high_run;
      logic found;
      logic in_train;
      low_run  = 0;
      found    = 1'b0;
      p1_len   = 0;
      p2_min   = 32'h7fff_ffff;
      p2_max   = 0;
      gap_min  = 32'h7fff_ffff;
      gap_max  = 0;
      n_pulses = 0;
      while (!found) begin
         @(negedge clk);
         if (!pulse) low_run++;
         else if (low_run > gap_limit) found = 1'b1;   // Rise after the idle stretch
         else low_run = 0;
      end
      in_train = 1'b1;
      while (in_train) begin
         high_run = 1;
         @(negedge clk);
         while (pulse) begin
            high_run++;
            @(negedge clk);
         end
         if (n_pulses == 0) begin
            p1_len = high_run;
         end else begin
            p2_min = (high_run < p2_min) ? high_run : p2_min;
            p2_max = (high_run > p2_max) ? high_run : p2_max;
         end
         n_pulses++;
         low_run = 1;
         while (!pulse && low_run <= gap_limit) begin
            @(negedge clk);
            if (!pulse) low_run++;
         end
         if (pulse) begin
            gap_min = (low_run < gap_min) ? low_run : gap_min;
            gap_max = (low_run > gap_max) ? low_run : gap_max;
         end else begin
            in_train = 1'b0;                       // Longer than a gap, period idle
         end
      end
   endtask

   task automatic run_row(input golden_t row);
      pulse_pkg::word_t w;
      int               p1_len;
      int               p2_min;
      int               p2_max;
      int               gap_min;
      int               gap_max;
      int               n_pulses;
      if (row.kind == "F") exchange_frame(row.cmd, row.data, row.echo);
      if (row.kind == "U") begin
         for (int i = 0; i < int'(row.data); i++) begin
            next_random_word(w);
            exchange_frame(row.cmd, w, 32'(checksum_of(w)));
         end
      end
      check_value("pre_att", row.pre, 32'(pre_att));
      check_value("post_att", row.post, 32'(post_att));
      // Second train is surely past any register change
      repeat (2) measure_period(row.gap, p1_len, p2_min, p2_max, gap_min, gap_max, n_pulses);
      check_value("pulse count", row.pulses, n_pulses);
      check_value("p1 width", row.p1, p1_len);
      if (n_pulses > 1) begin
         check_value("p2 width min", row.p2, p2_min);
         check_value("p2 width max", row.p2, p2_max);
         check_value("delay gap min", row.gap, gap_min);
         check_value("delay gap max", row.gap, gap_max);
      end
   endtask

   initial begin
      wait (wd_cycles > 0);
      repeat (wd_cycles) @(posedge clk);
      fail_run($sformatf("Run timed out after %0d clock cycles", wd_cycles));
   end

   initial begin
      clk        = 1'b0;
      rst_n      = 1'b0;
      rx         = 1'b1;                           // Idle line
      wd_cycles  = 0;
      lfsr_state = 32'h3969;
      load_golden();
      set_watchdog();
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      foreach (rows[i]) run_row(rows[i]);
      $display("test passed");
      $finish;
   end

endmodule

// ==== logic/pulse_top.sv ====
`timescale 1ns/1ps

module pulse_top #(
   parameter int CLKS_PER_BIT = 434             // 50 MHz at 115200 baud
) (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            rx,
   output logic            tx,
   output logic            pulse,
   output pulse_pkg::att_t pre_att,
   output pulse_pkg::att_t post_att
);

   pulse_pkg::byte_t   rx_byte;
   logic               rx_valid;
   pulse_pkg::byte_t   tx_byte;
   logic               tx_start;
   logic               tx_busy;
   pulse_pkg::period_t period;   // Register bank to sequencer
   pulse_pkg::time_t   p1width;
   pulse_pkg::time_t   p2width;
   pulse_pkg::time_t   delay;
   pulse_pkg::count_t  cpmg;

   // Host link
   uart_rx #(
      .CLKS_PER_BIT(CLKS_PER_BIT)
   ) uart_rx_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .rx      (rx),
      .rx_byte (rx_byte),
      .rx_valid(rx_valid)
   );

   uart_tx #(
      .CLKS_PER_BIT(CLKS_PER_BIT)
   ) uart_tx_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .tx_start(tx_start),
      .tx_byte (tx_byte),
      .tx      (tx),
      .tx_busy (tx_busy)
   );

   pulse_control pulse_control_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .rx_byte (rx_byte),
      .rx_valid(rx_valid),
      .tx_busy (tx_busy),
      .tx_byte (tx_byte),
      .tx_start(tx_start),
      .period  (period),
      .p1width (p1width),
      .p2width (p2width),
      .delay   (delay),
      .cpmg    (cpmg),
      .pre_att (pre_att),        // Straight to the pins
      .post_att(post_att)
   );

   pulse_sequencer pulse_sequencer_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .period (period),
      .p1width(p1width),
      .p2width(p2width),
      .delay  (delay),
      .cpmg   (cpmg),
      .pulse  (pulse)
   );

endmodule

// ==== logic/pulse_sequencer.sv ====
`timescale 1ns/1ps

module pulse_sequencer (
   input  logic               clk,
   input  logic               rst_n,
   input  pulse_pkg::period_t period,
   input  pulse_pkg::time_t   p1width,
   input  pulse_pkg::time_t   p2width,
   input  pulse_pkg::time_t   delay,
   input  pulse_pkg::count_t  cpmg,
   output logic               pulse
);

   pulse_pkg::seq_state_e state;
   pulse_pkg::seq_state_e nxt_state;
   pulse_pkg::period_t    per_left;     // Clocks left in this period
   pulse_pkg::time_t      seg_left;     // Clocks left in this segment
   pulse_pkg::time_t      nxt_left;
   pulse_pkg::count_t     rep_cnt;      // Refocusing pulses started
   pulse_pkg::count_t     nxt_rep;
   pulse_pkg::time_t      p1_r;         // Period snapshots
   pulse_pkg::time_t      p2_r;
   pulse_pkg::time_t      dly_r;
   pulse_pkg::count_t     cpmg_r;
   pulse_pkg::time_t      cur_p1;
   pulse_pkg::time_t      cur_p2;
   pulse_pkg::time_t      cur_dly;
   pulse_pkg::count_t     cur_cpmg;
   logic                  restart;

   assign restart  = (per_left == '0);
   // Live values on the restart cycle, snapshot otherwise
   assign cur_p1   = restart ? p1width : p1_r;
   assign cur_p2   = restart ? p2width : p2_r;
   assign cur_dly  = restart ? delay   : dly_r;
   assign cur_cpmg = restart ? cpmg    : cpmg_r;

   // Next segment, hopping over zero-length ones
   always_comb begin
      logic             adv;
      logic             enter;
      pulse_pkg::time_t len;
      nxt_state = state;
      nxt_left  = seg_left;
      nxt_rep   = rep_cnt;
      adv       = 1'b0;
      enter     = restart;
      len       = '0;
      if (restart) begin
         nxt_state = pulse_pkg::SEQ_P1;
         nxt_rep   = '0;
      end else if (state != pulse_pkg::SEQ_IDLE) begin
         if (seg_left == '0) adv = 1'b1;
         else nxt_left = seg_left - 1'b1;
      end
      for (int i = 0; i < 8; i++) begin
         if (adv) begin
            case (nxt_state)
               pulse_pkg::SEQ_DELAY: begin
                  if (nxt_rep < cur_cpmg) begin
                     nxt_state = pulse_pkg::SEQ_P2;
                     nxt_rep   = nxt_rep + 1'b1;
                  end else begin
                     nxt_state = pulse_pkg::SEQ_IDLE;   // Train done
                  end
               end
               pulse_pkg::SEQ_IDLE: nxt_state = pulse_pkg::SEQ_IDLE;
               default: nxt_state = pulse_pkg::SEQ_DELAY;   // After either pulse
            endcase
            adv   = 1'b0;
            enter = 1'b1;
         end else if (enter) begin
            case (nxt_state)
               pulse_pkg::SEQ_P1:    len = cur_p1;
               pulse_pkg::SEQ_P2:    len = cur_p2;
               pulse_pkg::SEQ_DELAY: len = cur_dly;
               default:              len = 16'd1;
            endcase
            if (len == '0) begin
               adv = 1'b1;                           // Skip empty segment
            end else begin
               nxt_left = len - 1'b1;
               enter    = 1'b0;
            end
         end
      end
      if (enter || adv) nxt_left = '0;              // Degenerate all-zero train
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state    <= pulse_pkg::SEQ_IDLE;
         per_left <= '0;                             // Restart on first cycle out of reset
         seg_left <= '0;
         rep_cnt  <= '0;
      end else begin
         state    <= nxt_state;
         seg_left <= nxt_left;
         rep_cnt  <= nxt_rep;
         if (restart) per_left <= (period > 32'd1) ? period - 32'd1 : '0;
         else per_left <= per_left - 1'b1;
      end
   end

   // Timing held for the whole period
   always_ff @(posedge clk) begin
      if (restart) begin
         p1_r   <= p1width;
         p2_r   <= p2width;
         dly_r  <= delay;
         cpmg_r <= cpmg;
      end
   end

   assign pulse = (state == pulse_pkg::SEQ_P1) || (state == pulse_pkg::SEQ_P2);

endmodule

// ==== logic/pulse_control.sv ====
`timescale 1ns/1ps

module pulse_control (
   input  logic               clk,
   input  logic               rst_n,
   input  pulse_pkg::byte_t   rx_byte,
   input  logic               rx_valid,
   input  logic               tx_busy,
   output pulse_pkg::byte_t   tx_byte,
   output logic               tx_start,
   output pulse_pkg::period_t period,
   output pulse_pkg::time_t   p1width,
   output pulse_pkg::time_t   p2width,
   output pulse_pkg::time_t   delay,
   output pulse_pkg::count_t  cpmg,
   output pulse_pkg::att_t    pre_att,
   output pulse_pkg::att_t    post_att
);

   // Index of the command byte within a frame
   localparam logic [2:0] CMD_BYTE = 3'(pulse_pkg::FRAME_DATA_BYTES);

   pulse_pkg::ctrl_state_e state;
   logic [2:0]             byte_cnt;     // Bytes taken so far
   pulse_pkg::word_t       data_word;    // Little-endian payload
   pulse_pkg::cmd_e        cmd;
   pulse_pkg::byte_t       checksum;

   // Sum of the data bytes, modulo 256
   always_comb begin
      checksum = '0;
      for (int i = 0; i < pulse_pkg::FRAME_DATA_BYTES; i++) begin
         checksum = checksum + data_word[8*i +: 8];
      end
   end

   // One cycle strobe, only with the transmitter free
   assign tx_start = (state == pulse_pkg::CTRL_SEND_WAIT) && !tx_busy;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state    <= pulse_pkg::CTRL_RECEIVE;
         byte_cnt <= '0;
         period   <= pulse_pkg::RST_PERIOD;
         p1width  <= pulse_pkg::RST_P1WIDTH;
         p2width  <= pulse_pkg::RST_P2WIDTH;
         delay    <= pulse_pkg::RST_DELAY;
         cpmg     <= pulse_pkg::RST_CPMG;
         pre_att  <= pulse_pkg::RST_PRE_ATT;
         post_att <= pulse_pkg::RST_POST_ATT;
      end else begin
         case (state)
            pulse_pkg::CTRL_RECEIVE: begin
               if (rx_valid) begin
                  if (byte_cnt == CMD_BYTE) begin
                     byte_cnt <= '0;
                     state    <= pulse_pkg::CTRL_DECODE;   // Command byte in
                  end else begin
                     byte_cnt <= byte_cnt + 1'b1;
                  end
               end
            end
            pulse_pkg::CTRL_DECODE: begin
               // One register per command
               case (cmd)
                  pulse_pkg::CMD_SET_DELAY:  delay   <= data_word[15:0];
                  pulse_pkg::CMD_SET_PERIOD: period  <= data_word;
                  pulse_pkg::CMD_SET_PULSE1: p1width <= data_word[15:0];
                  pulse_pkg::CMD_SET_PULSE2: p2width <= data_word[15:0];
                  pulse_pkg::CMD_SET_CPMG:   cpmg    <= data_word[7:0];
                  pulse_pkg::CMD_SET_ATT: begin
                     pre_att  <= data_word[6:0];
                     post_att <= data_word[14:8];
                  end
                  default: ;                               // Unknown code, echo only
               endcase
               state <= pulse_pkg::CTRL_SEND_WAIT;
            end
            pulse_pkg::CTRL_SEND_WAIT: begin
               if (!tx_busy) state <= pulse_pkg::CTRL_SEND_DONE;   // tx_start fires now
            end
            pulse_pkg::CTRL_SEND_DONE: begin
               // Busy is already up here, wait for the stop bit
               if (!tx_busy) state <= pulse_pkg::CTRL_RECEIVE;
            end
            default: state <= pulse_pkg::CTRL_RECEIVE;
         endcase
      end
   end

   // Frame payload and echo byte
   always_ff @(posedge clk) begin
      if (state == pulse_pkg::CTRL_RECEIVE && rx_valid) begin
         if (byte_cnt == CMD_BYTE) begin
            cmd <= pulse_pkg::cmd_e'(rx_byte);
         end else begin
            data_word[8*byte_cnt +: 8] <= rx_byte;   // LSB byte first
         end
      end
      if (state == pulse_pkg::CTRL_DECODE) tx_byte <= checksum;
   end

endmodule

// ==== uart/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx #(
   parameter int CLKS_PER_BIT = 434             // Clocks per bit time
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             tx_start,
   input  pulse_pkg::byte_t tx_byte,
   output logic             tx,
   output logic             tx_busy
);

   localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
   localparam logic [CNT_W-1:0] BIT_END = CNT_W'(CLKS_PER_BIT - 1);

   logic [CNT_W-1:0] clk_cnt;
   logic [3:0]       bit_idx;       // 0 start, 1 to 8 data, 9 stop
   pulse_pkg::byte_t data_reg;
   logic             bit_end;
   logic             last_bit;

   assign bit_end  = (clk_cnt == BIT_END);
   assign last_bit = (bit_idx == 4'd9);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         tx      <= 1'b1;           // Idle level
         tx_busy <= 1'b0;
         clk_cnt <= '0;
         bit_idx <= '0;
      end else if (!tx_busy) begin
         if (tx_start) begin
            tx      <= 1'b0;        // Start bit
            tx_busy <= 1'b1;
            clk_cnt <= '0;
            bit_idx <= '0;
         end
      end else if (bit_end) begin
         clk_cnt <= '0;
         if (last_bit) begin
            tx_busy <= 1'b0;        // Stop bit done, line already high
         end else begin
            bit_idx <= bit_idx + 1'b1;
            tx      <= data_reg[0];
         end
      end else begin
         clk_cnt <= clk_cnt + 1'b1;
      end
   end

   // Ones shift in behind the data and form the stop bit
   always_ff @(posedge clk) begin
      if (!tx_busy && tx_start) begin
         data_reg <= tx_byte;
      end else if (tx_busy && bit_end && !last_bit) begin
         data_reg <= {1'b1, data_reg[7:1]};
      end
   end

endmodule

// ==== uart/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx #(
   parameter int CLKS_PER_BIT = 434             // Clocks per bit time
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             rx,
   output pulse_pkg::byte_t rx_byte,
   output logic             rx_valid
);

   localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
   localparam logic [CNT_W-1:0] BIT_END  = CNT_W'(CLKS_PER_BIT - 1);
   localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'((CLKS_PER_BIT - 1) / 2);

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_e;

   rx_state_e        state;
   logic             rx_meta;       // First sync stage
   logic             rx_sync;       // Safe to sample
   logic [CNT_W-1:0] clk_cnt;
   logic [2:0]       bit_idx;
   pulse_pkg::byte_t shift_reg;
   logic             bit_end;

   assign bit_end = (clk_cnt == BIT_END);

   // Line idles high
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state    <= RX_IDLE;
         clk_cnt  <= '0;
         bit_idx  <= '0;
         rx_valid <= 1'b0;
      end else begin
         rx_valid <= 1'b0;
         case (state)
            RX_IDLE: begin
               clk_cnt <= '0;
               bit_idx <= '0;
               if (!rx_sync) state <= RX_START;    // Falling edge
            end
            RX_START: begin
               if (clk_cnt == HALF_BIT) begin
                  clk_cnt <= '0;                   // Now aligned to mid-bit
                  if (rx_sync) state <= RX_IDLE;   // Glitch, not a start bit
                  else state <= RX_DATA;
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            RX_DATA: begin
               if (bit_end) begin
                  clk_cnt <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) state <= RX_STOP;
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            RX_STOP: begin
               if (bit_end) begin
                  state    <= RX_IDLE;
                  rx_valid <= rx_sync;             // Framing error drops the byte
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
         endcase
      end
   end

   // LSB arrives first
   always_ff @(posedge clk) begin
      if (state == RX_DATA && bit_end) shift_reg <= {rx_sync, shift_reg[7:1]};
      if (state == RX_STOP && bit_end && rx_sync) rx_byte <= shift_reg;
   end

endmodule

// ==== common/pulse_pkg.sv ====
package pulse_pkg;

   // Widths that carry a meaning
   typedef logic [7:0]  byte_t;     // One UART byte
   typedef logic [31:0] word_t;     // Frame payload
   typedef logic [31:0] period_t;   // Period in clocks
   typedef logic [15:0] time_t;     // Width or delay in clocks
   typedef logic [7:0]  count_t;    // Refocusing pulse count
   typedef logic [6:0]  att_t;      // Attenuator step

   // Data bytes ahead of the command byte
   localparam int FRAME_DATA_BYTES = 4;

   // Command byte codes, gaps are unused codes
   typedef enum logic [7:0] {
      CMD_SET_DELAY  = 8'd0,
      CMD_SET_PERIOD = 8'd1,
      CMD_SET_PULSE1 = 8'd2,
      CMD_SET_PULSE2 = 8'd3,
      CMD_SET_CPMG   = 8'd5,
      CMD_SET_ATT    = 8'd6
   } cmd_e;

   typedef enum logic [1:0] {
      CTRL_RECEIVE,     // Collecting frame bytes
      CTRL_DECODE,      // Register write and checksum
      CTRL_SEND_WAIT,   // Waiting for a free transmitter
      CTRL_SEND_DONE    // Echo on the line
   } ctrl_state_e;

   typedef enum logic [1:0] {
      SEQ_P1,           // Excitation pulse
      SEQ_DELAY,        // Gap after each pulse
      SEQ_P2,           // Refocusing pulse
      SEQ_IDLE          // Rest of the period
   } seq_state_e;

   // Register values after reset
   localparam period_t RST_PERIOD   = 32'd2000;
   localparam time_t   RST_P1WIDTH  = 16'd40;
   localparam time_t   RST_P2WIDTH  = 16'd40;
   localparam time_t   RST_DELAY    = 16'd150;
   localparam count_t  RST_CPMG     = 8'd1;
   localparam att_t    RST_PRE_ATT  = 7'd0;
   localparam att_t    RST_POST_ATT = 7'd127;   // Full attenuation

endpackage
